// ==== src/dma_macros.svh ====
// DMA cluster constants
// Port count, interleave region, address and length widths, beat size

`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Number of backend ports behind the split stage
`define DMA_NUM_PORTS 4

// Bytes one port owns inside each interleave window
`define DMA_REGION_BYTES 64

// Bounds of the banked address region
`define DMA_REGION_START 32'h0000_0000
`define DMA_REGION_END 32'h1000_0000

// Request field widths
`define DMA_ADDR_WIDTH 32
`define DMA_LEN_WIDTH 16

// Backend beat size and the width of a beat's byte count
`define DMA_BEAT_BYTES 4
`define DMA_BEAT_NB_WIDTH 3

`endif

// ==== src/dma_pkg.sv ====
// DMA cluster types
// Burst request, per-port status, memory-side beat and backend FSM states

`default_nettype none

`include "dma_macros.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMA_LEN_WIDTH-1:0] len_t;
  typedef logic [`DMA_BEAT_NB_WIDTH-1:0] beat_nb_t;

  // One copy request, or one slice of it
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } burst_req_t;

  // Completion pulse and idle level
  typedef struct packed {
    logic trans_complete;
    logic backend_idle;
  } dma_meta_t;

  // What a backend puts on its memory side each cycle
  typedef struct packed {
    logic     valid;
    addr_t    src;
    addr_t    dst;
    beat_nb_t nbytes;
  } dma_beat_t;

  typedef enum logic [1:0] {
    BE_IDLE,
    BE_BUSY,
    BE_DONE
  } backend_state_e;

endpackage

`default_nettype wire

// ==== src/dma_stream_fork.sv ====
// Stream fork
// Copies one valid/ready stream to NumPorts outputs and completes the input
// handshake once every output has accepted, in this cycle or an earlier one

`default_nettype none

module dma_stream_fork #(
  parameter int unsigned NumPorts = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                valid_i,
  output logic                     ready_o,
  output logic      [NumPorts-1:0] valid_o,
  input  wire logic [NumPorts-1:0] ready_i
);

  // Outputs that already took the current item
  logic [NumPorts-1:0] taken_d, taken_q;
  logic [NumPorts-1:0] accepted;

  // Do not offer the item again to an output that has it
  assign valid_o = {NumPorts{valid_i}} & ~taken_q;

  assign accepted = valid_o & ready_i;

  // Every output either had it before or is taking it now
  assign ready_o = &(taken_q | ready_i);

  always_comb begin
    taken_d = taken_q | accepted;
    if (valid_i && ready_o) begin
      taken_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= '0;
    end else begin
      taken_q <= taken_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_split_midend.sv ====
// Distributing midend
// Cuts one copy request into one slice per backend port by address window,
// ties off ports outside the transfer and merges the per-port status

`default_nettype none

`include "dma_macros.svh"

module dma_split_midend
  import dma_pkg::*;
#(
  parameter int unsigned NumPorts = 4
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  // Request side
  input  wire burst_req_t                 burst_req_i,
  input  wire logic                       valid_i,
  output logic                            ready_o,
  output dma_meta_t                       meta_o,
  // Backend side
  output burst_req_t     [NumPorts-1:0]   burst_req_o,
  output logic           [NumPorts-1:0]   valid_o,
  input  wire logic      [NumPorts-1:0]   ready_i,
  input  wire dma_meta_t [NumPorts-1:0]   meta_i
);

  localparam int unsigned RegionBytes = `DMA_REGION_BYTES;
  localparam int unsigned RegionBits  = $clog2(RegionBytes);
  localparam int unsigned FullBits    = $clog2(RegionBytes * NumPorts);

  // Offsets inside the interleave window, one bit wider than a length
  typedef logic [`DMA_LEN_WIDTH:0] span_t;

  logic [NumPorts-1:0] fork_valid, fork_ready;
  logic [NumPorts-1:0] tie_off;
  logic                fork_in_valid, fork_in_ready;
  logic                busy_d, busy_q;
  logic                src_in_region;
  span_t               start_addr, end_addr;

  logic [NumPorts-1:0] done_d, done_q;
  logic [NumPorts-1:0] idle_q;

  // Status merge
  assign meta_o.trans_complete = &done_q;
  assign meta_o.backend_idle   = &idle_q;

  always_comb begin
    done_d = done_q;
    for (int i = 0; i < NumPorts; i++) begin
      done_d[i] = done_q[i] | meta_i[i].trans_complete | tie_off[i];
    end
    if (meta_o.trans_complete) begin
      done_d = '0;
    end
  end

  // Only one request in flight, so the merged pulse belongs to it
  always_comb begin
    busy_d = busy_q;
    if (valid_i && ready_o) begin
      busy_d = 1'b1;
    end else if (meta_o.trans_complete) begin
      busy_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= '0;
      idle_q <= '1;
      busy_q <= 1'b0;
    end else begin
      done_q <= done_d;
      busy_q <= busy_d;
      for (int i = 0; i < NumPorts; i++) begin
        idle_q[i] <= meta_i[i].backend_idle;
      end
    end
  end

  assign fork_in_valid = valid_i & ~busy_q;
  assign ready_o       = fork_in_ready & ~busy_q;

  dma_stream_fork #(
    .NumPorts (NumPorts)
  ) i_fork (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (fork_in_valid),
    .ready_o (fork_in_ready),
    .valid_o (fork_valid),
    .ready_i (fork_ready)
  );

  // Region check as one unsigned compare
  assign src_in_region = (burst_req_i.src - `DMA_REGION_START) <
                         (`DMA_REGION_END - `DMA_REGION_START);

  // The side inside the region decides the cut
  always_comb begin
    if (src_in_region) begin
      start_addr = span_t'(burst_req_i.src[FullBits-1:0]);
    end else begin
      start_addr = span_t'(burst_req_i.dst[FullBits-1:0]);
    end
    end_addr = start_addr + span_t'(burst_req_i.num_bytes);
  end

  always_comb begin
    span_t win_lo;
    span_t win_hi;
    span_t offset;
    valid_o    = fork_valid;
    fork_ready = ready_i;
    tie_off    = '0;
    for (int i = 0; i < NumPorts; i++) begin
      win_lo = span_t'(i * RegionBytes);
      win_hi = span_t'((i + 1) * RegionBytes);
      // Distance from the request start to this port's window
      offset = win_lo - start_addr;
      burst_req_o[i] = burst_req_i;
      if ((start_addr >= win_hi) || (end_addr <= win_lo)) begin
        // Outside the transfer, handshake and complete locally
        burst_req_o[i] = '0;
        valid_o[i]     = 1'b0;
        fork_ready[i]  = 1'b1;
        tie_off[i]     = fork_valid[i];
      end else if (start_addr >= win_lo) begin
        // First slice, may also be the only one
        if (end_addr > win_hi) begin
          burst_req_o[i].num_bytes = len_t'(win_hi - start_addr);
        end
      end else begin
        // Window base on the split side, same offset on the other side
        if (src_in_region) begin
          burst_req_o[i].src[FullBits-1:0] = win_lo[FullBits-1:0];
          burst_req_o[i].dst = burst_req_i.dst + addr_t'(offset);
        end else begin
          burst_req_o[i].src = burst_req_i.src + addr_t'(offset);
          burst_req_o[i].dst[FullBits-1:0] = win_lo[FullBits-1:0];
        end
        if (end_addr >= win_hi) begin
          burst_req_o[i].num_bytes = len_t'(RegionBytes);
        end else begin
          // Last slice
          burst_req_o[i].num_bytes = len_t'(end_addr[RegionBits-1:0]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_port_backend.sv ====
// Per-port DMA backend
// Takes one slice and walks it in fixed-size beats, then pulses completion

`default_nettype none

`include "dma_macros.svh"

module dma_port_backend
  import dma_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire burst_req_t burst_req_i,
  input  wire logic       valid_i,
  output logic            ready_o,
  output dma_meta_t       meta_o,
  output dma_beat_t       beat_o
);

  backend_state_e state_d, state_q;

  addr_t    src_q, dst_q;
  len_t     rem_q;
  beat_nb_t beat_nb;
  logic     accept;
  logic     last_beat;

  assign ready_o = (state_q == BE_IDLE);
  assign accept  = valid_i & ready_o;

  // Final beat carries whatever is left
  assign last_beat = (rem_q <= len_t'(`DMA_BEAT_BYTES));
  assign beat_nb   = last_beat ? beat_nb_t'(rem_q) : beat_nb_t'(`DMA_BEAT_BYTES);

  always_comb begin
    state_d = state_q;
    case (state_q)
      BE_IDLE: begin
        if (accept) begin
          // Empty slice has no beats
          if (burst_req_i.num_bytes == '0) begin
            state_d = BE_DONE;
          end else begin
            state_d = BE_BUSY;
          end
        end
      end
      BE_BUSY: begin
        if (last_beat) begin
          state_d = BE_DONE;
        end
      end
      BE_DONE: state_d = BE_IDLE;
      default: state_d = BE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Beat pointers and remaining bytes
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q <= burst_req_i.src;
      dst_q <= burst_req_i.dst;
      rem_q <= burst_req_i.num_bytes;
    end else if (state_q == BE_BUSY) begin
      src_q <= src_q + addr_t'(`DMA_BEAT_BYTES);
      dst_q <= dst_q + addr_t'(`DMA_BEAT_BYTES);
      rem_q <= rem_q - len_t'(beat_nb);
    end
  end

  always_comb begin
    beat_o.valid  = (state_q == BE_BUSY);
    beat_o.src    = src_q;
    beat_o.dst    = dst_q;
    beat_o.nbytes = beat_nb;
  end

  assign meta_o.trans_complete = (state_q == BE_DONE);
  assign meta_o.backend_idle   = (state_q == BE_IDLE);

endmodule

`default_nettype wire

// ==== src/dma_cluster_top.sv ====
// DMA cluster
// Split midend in front of one beat-walking backend per memory port

`default_nettype none

`include "dma_macros.svh"

module dma_cluster_top
  import dma_pkg::*;
(
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire burst_req_t                      burst_req_i,
  input  wire logic                            valid_i,
  output logic                                 ready_o,
  output dma_meta_t                            meta_o,
  output dma_beat_t      [`DMA_NUM_PORTS-1:0]  beat_o
);

  burst_req_t [`DMA_NUM_PORTS-1:0] slice_req;
  logic       [`DMA_NUM_PORTS-1:0] slice_valid;
  logic       [`DMA_NUM_PORTS-1:0] slice_ready;
  dma_meta_t  [`DMA_NUM_PORTS-1:0] slice_meta;

  dma_split_midend #(
    .NumPorts (`DMA_NUM_PORTS)
  ) i_midend (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .burst_req_i (burst_req_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .meta_o      (meta_o),
    .burst_req_o (slice_req),
    .valid_o     (slice_valid),
    .ready_i     (slice_ready),
    .meta_i      (slice_meta)
  );

  // One backend per bank port
  for (genvar p = 0; p < `DMA_NUM_PORTS; p++) begin : gen_ports
    dma_port_backend i_backend (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .burst_req_i (slice_req[p]),
      .valid_i     (slice_valid[p]),
      .ready_o     (slice_ready[p]),
      .meta_o      (slice_meta[p]),
      .beat_o      (beat_o[p])
    );
  end

endmodule

`default_nettype wire

// ==== dv/tb_dma_cluster.sv ====
// DMA cluster testbench
// Drives copy requests, predicts the beats of every port from the address
// windows and checks each beat as it appears on the memory side

`default_nettype none

`include "dma_macros.svh"

module tb_dma_cluster
  import dma_pkg::*;
();

  localparam int NumPorts = `DMA_NUM_PORTS;
  localparam int WinBytes = `DMA_NUM_PORTS * `DMA_REGION_BYTES;
  localparam int Timeout  = 400;

  logic                      clk_i;
  logic                      rst_ni;
  burst_req_t                burst_req_i;
  logic                      valid_i;
  logic                      ready_o;
  dma_meta_t                 meta_o;
  dma_beat_t  [NumPorts-1:0] beat_o;

  // Expected beats per port, oldest first
  dma_beat_t exp_q [NumPorts][$];

  int error_count;
  int errors_at_start;
  int complete_count;
  int test_count;
  int test_fail_count;
  int seed;

  dma_cluster_top DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .burst_req_i (burst_req_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .meta_o      (meta_o),
    .beat_o      (beat_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Each port gets the part of the request that falls in its own window
  function automatic void predict_beats(input burst_req_t req);
    int        start;
    int        stop;
    int        lo;
    int        hi;
    int        len;
    int        off;
    dma_beat_t beat;
    // Region starts at address zero
    if (req.src < `DMA_REGION_END) begin
      start = int'(req.src % addr_t'(WinBytes));
    end else begin
      start = int'(req.dst % addr_t'(WinBytes));
    end
    stop = start + int'(req.num_bytes);
    for (int p = 0; p < NumPorts; p++) begin
      lo  = (p * `DMA_REGION_BYTES > start) ? p * `DMA_REGION_BYTES : start;
      hi  = ((p + 1) * `DMA_REGION_BYTES < stop) ? (p + 1) * `DMA_REGION_BYTES : stop;
      len = hi - lo;
      off = lo - start;
      for (int k = 0; k < len; k += `DMA_BEAT_BYTES) begin
        beat.valid  = 1'b1;
        beat.src    = req.src + addr_t'(off + k);
        beat.dst    = req.dst + addr_t'(off + k);
        beat.nbytes = beat_nb_t'((len - k < `DMA_BEAT_BYTES) ? len - k : `DMA_BEAT_BYTES);
        exp_q[p].push_back(beat);
      end
    end
  endfunction

  task automatic check_value(input string signal, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("Error: time %0t %s expected %h actual %h", $time, signal, expected, actual);
      error_count++;
    end
  endtask

  // Beat checker and completion counter
  initial begin
    dma_beat_t exp;
    logic      beat_seen;
    logic      prev_seen;
    prev_seen = 1'b0;
    forever begin
      @(negedge clk_i);
      beat_seen = 1'b0;
      if (rst_ni) begin
        if (meta_o.trans_complete) begin
          complete_count++;
        end
        // Idle flag trails the backends by one cycle
        if (prev_seen) begin
          check_value("meta_o.backend_idle", 32'd0, 32'(meta_o.backend_idle));
        end
        for (int p = 0; p < NumPorts; p++) begin
          if (beat_o[p].valid) begin
            beat_seen = 1'b1;
            assert (exp_q[p].size() > 0) else begin
              $display("Error: time %0t unexpected beat on port %0d", $time, p);
              error_count++;
            end
            if (exp_q[p].size() > 0) begin
              exp = exp_q[p].pop_front();
              check_value($sformatf("beat_o[%0d].src", p), exp.src, beat_o[p].src);
              check_value($sformatf("beat_o[%0d].dst", p), exp.dst, beat_o[p].dst);
              check_value($sformatf("beat_o[%0d].nbytes", p), 32'(exp.nbytes),
                          32'(beat_o[p].nbytes));
            end
          end
        end
      end
      prev_seen = beat_seen;
    end
  end

  // Holds the request until the handshake, returns the cycles it waited
  task automatic drive_request(input burst_req_t req, output int cycles);
    logic accepted;
    accepted = 1'b0;
    cycles   = 0;
    @(posedge clk_i);
    burst_req_i <= req;
    valid_i     <= 1'b1;
    while (!accepted && cycles < Timeout) begin
      @(negedge clk_i);
      accepted = ready_o;
      @(posedge clk_i);
      cycles++;
    end
    valid_i <= 1'b0;
    if (!accepted) begin
      $display("Timeout: request was never accepted by the DUT");
      error_count++;
    end
  endtask

  task automatic wait_complete(input int target);
    int cycles;
    cycles = 0;
    while (complete_count < target && cycles < Timeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (complete_count < target) begin
      $display("Timeout: the transfer never signalled completion");
      error_count++;
    end
  endtask

  task automatic check_drained();
    for (int p = 0; p < NumPorts; p++) begin
      assert (exp_q[p].size() == 0) else begin
        $display("Error: port %0d never produced %0d expected beats", p, exp_q[p].size());
        error_count++;
        exp_q[p].delete();
      end
    end
  endtask

  task automatic run_request(input burst_req_t req);
    int cycles;
    int target;
    target = complete_count + 1;
    predict_beats(req);
    drive_request(req, cycles);
    wait_complete(target);
    check_drained();
  endtask

  task automatic run_random(input int count);
    burst_req_t req;
    addr_t      rnd;
    int         start;
    for (int n = 0; n < count; n++) begin
      rnd   = $random(seed);
      start = int'(rnd % addr_t'(WinBytes));
      rnd   = $random(seed);
      req.num_bytes = len_t'(1 + int'(rnd % addr_t'(WinBytes - start)));
      rnd = $random(seed);
      if (rnd[0]) begin
        req.src = (rnd & ~addr_t'(WinBytes - 1) & 32'h0FFF_FFFF) | addr_t'(start);
        req.dst = $random(seed);
      end else begin
        // Source above the region, split on dst
        req.src = 32'h8000_0000 | (rnd & 32'h0FFF_FFFF);
        rnd     = $random(seed);
        req.dst = (rnd & ~addr_t'(WinBytes - 1) & 32'h0FFF_FFFF) | addr_t'(start);
      end
      run_request(req);
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == errors_at_start) begin
      $display("%s: ok", name);
    end else begin
      test_fail_count++;
      $display("%s: %0d errors", name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  initial begin
    burst_req_t req;
    int         cycles;
    int         first_beats;
    int         target;
    seed            = 32'h652cd27c;
    error_count     = 0;
    errors_at_start = 0;
    complete_count  = 0;
    test_count      = 0;
    test_fail_count = 0;
    rst_ni          = 1'b0;
    valid_i         = 1'b0;
    burst_req_i     = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check_value("ready_o", 32'd1, 32'(ready_o));
    check_value("meta_o.backend_idle", 32'd1, 32'(meta_o.backend_idle));
    check_value("meta_o.trans_complete", 32'd0, 32'(meta_o.trans_complete));
    for (int p = 0; p < NumPorts; p++) begin
      check_value($sformatf("beat_o[%0d].valid", p), 32'd0, 32'(beat_o[p].valid));
    end
    finish_test("reset state");

    // Inside the window of port 1
    target = complete_count + 1;
    req    = '{src: 32'h0000_1048, dst: 32'h0040_2000, num_bytes: 16'd20};
    run_request(req);
    repeat (4) @(posedge clk_i);
    check_value("meta_o.trans_complete cycles", target, complete_count);
    finish_test("single port request");

    req = '{src: 32'h0000_3010, dst: 32'h0050_0123, num_bytes: 16'd200};
    run_request(req);
    finish_test("multi port request");

    req = '{src: 32'h2000_0777, dst: 32'h0000_5030, num_bytes: 16'd150};
    run_request(req);
    finish_test("destination split");

    // Second request waits for the whole first one
    target = complete_count + 2;
    req    = '{src: 32'h0000_0000, dst: 32'h0060_0000, num_bytes: 16'd256};
    predict_beats(req);
    first_beats = exp_q[0].size();
    drive_request(req, cycles);
    req = '{src: 32'h0000_0084, dst: 32'h0070_0000, num_bytes: 16'd100};
    predict_beats(req);
    drive_request(req, cycles);
    assert (cycles > first_beats) else begin
      $display("Error: second request taken after %0d cycles while the first had %0d beats",
               cycles, first_beats);
      error_count++;
    end
    wait_complete(target);
    check_drained();
    finish_test("back-pressure");

    run_random(40);
    finish_test("random requests");

    $display("tests %0d, failed %0d, errors %0d", test_count, test_fail_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/dma_pkg.sv
src/dma_stream_fork.sv
src/dma_split_midend.sv
src/dma_port_backend.sv
src/dma_cluster_top.sv
dv/tb_dma_cluster.sv

// ==== Makefile ====
# Verilator flow for the DMA cluster

TOP := tb_dma_cluster
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module dma_cluster_top

sim:
	verilator --binary --timing --assert -j 0 -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
